// File: tb.f
verilog/fifo_cfg_pkg.sv
verilog/fifo_types_pkg.sv
verilog/ram_2p.sv
verilog/ram_2p_asym.sv
verilog/fifo_wr_ctrl.sv
verilog/fifo_rd_ctrl.sv
verilog/asym_fifo.sv
test/tb_asym_fifo.sv

// File: test/tb_asym_fifo.sv
`timescale 1ns/1ns

module tb_asym_fifo import fifo_types_pkg::*;;

   localparam int w_data_w = 32;
   localparam int r_data_w = 8;
   localparam int addr_w   = 6;
   // narrow entries in the whole FIFO and per wide word
   localparam int depth    = 2**addr_w;
   localparam int w_unit   = w_data_w / r_data_w;

   logic                clk;
   logic                rst_n;
   logic                w_en;
   logic [w_data_w-1:0] w_data;
   logic                r_en;
   logic [r_data_w-1:0] r_data;
   logic                r_valid;
   fifo_side_t          wr_status;
   fifo_side_t          rd_status;

   // bytes stored in the FIFO, oldest first
   logic [r_data_w-1:0] ref_q [$];
   // bytes of accepted reads waiting for r_valid
   logic [r_data_w-1:0] exp_q [$];

   string cur_test;
   int    test_errs;
   int    total_errs;
   int    n_tests;
   int    n_failed;
   int    n_checks;

   asym_fifo #(
      .w_data_w (w_data_w),
      .r_data_w (r_data_w),
      .addr_w   (addr_w)
   ) i_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .w_en      (w_en),
      .w_data    (w_data),
      .r_en      (r_en),
      .r_data    (r_data),
      .r_valid   (r_valid),
      .wr_status (wr_status),
      .rd_status (rd_status)
   );

   always #4 clk = ~clk;

   // little-endian split with the lowest slice read first
   function automatic void split_word(input logic [w_data_w-1:0] word);
      for (int i = 0; i < w_unit; i++) begin
         ref_q.push_back(word[i*r_data_w +: r_data_w]);
      end
   endfunction

   task automatic value_mismatch(input string what, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
      $display("Fail %s: %s expected %0h actual %0h", cur_test, what, exp_v, act_v);
      test_errs++;
   endtask

   task automatic flag_problem(input string msg);
      $display("error in %s: %s", cur_test, msg);
      test_errs++;
   endtask

   task automatic give_up(input string msg);
      $display("timeout in %s: %s", cur_test, msg);
      $display("TEST FAILED");
      $finish;
   endtask

   task automatic close_test();
      n_tests++;
      total_errs += test_errs;
      if (test_errs == 0) begin
         $display("%s: passed", cur_test);
      end else begin
         $display("%s: %0d errors", cur_test, test_errs);
         n_failed++;
      end
      test_errs = 0;
   endtask

   // called 1 ns after a rising edge, returns 1 ns after the next one
   task automatic drive_cycle(input logic w, input logic [w_data_w-1:0] wd, input logic r);
      logic exp_full;
      logic exp_empty;
      logic acc_w;
      logic acc_r;
      exp_full  = (depth - ref_q.size()) < w_unit;
      exp_empty = ref_q.size() < 1;
      n_checks++;
      if (wr_status.stop !== exp_full) begin
         value_mismatch("full", exp_full, wr_status.stop);
      end
      if (rd_status.stop !== exp_empty) begin
         value_mismatch("empty", exp_empty, rd_status.stop);
      end
      acc_w  = w && !exp_full;
      acc_r  = r && !exp_empty;
      w_en   = w;
      w_data = wd;
      r_en   = r;
      @(posedge clk);
      // read sees the contents from before this edge
      if (acc_r) begin
         exp_q.push_back(ref_q.pop_front());
      end
      if (acc_w) begin
         split_word(wd);
      end
      #1;
      w_en = 1'b0;
      r_en = 1'b0;
   endtask

   task automatic fill_up(output int n);
      n = 0;
      while (wr_status.stop !== 1'b1) begin
         if (n == 2 * depth) begin
            give_up("FIFO never became full");
         end
         drive_cycle(1'b1, $urandom, 1'b0);
         n++;
      end
   endtask

   task automatic empty_out(output int n);
      n = 0;
      while (rd_status.stop !== 1'b1) begin
         if (n == 2 * depth) begin
            give_up("FIFO never became empty");
         end
         drive_cycle(1'b0, '0, 1'b1);
         n++;
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0) begin
         if (n == 10) begin
            give_up("read data never returned");
         end
         @(posedge clk);
         #1;
         n++;
      end
   endtask

   // outputs are stable at the falling edge
   always @(negedge clk) begin
      logic [r_data_w-1:0] exp_b;
      if (rst_n === 1'b1) begin
         if (r_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
               flag_problem("r_valid without an accepted read the cycle before");
            end else begin
               exp_b = exp_q.pop_front();
               n_checks++;
               if (r_data !== exp_b) begin
                  value_mismatch("r_data", exp_b, r_data);
               end
            end
         end else if (exp_q.size() != 0) begin
            flag_problem("no r_valid one cycle after an accepted read");
            exp_q.delete();
         end
      end
   end

   initial begin
      #100us;
      give_up("simulation ran too long");
   end

   initial begin
      int n;
      void'($urandom(32'h2001bb75));
      clk        = 1'b0;
      rst_n      = 1'b0;
      w_en       = 1'b0;
      w_data     = '0;
      r_en       = 1'b0;
      test_errs  = 0;
      total_errs = 0;
      n_tests    = 0;
      n_failed   = 0;
      n_checks   = 0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;

      cur_test = "reset";
      if (rd_status !== 2'b10) begin
         value_mismatch("rd_status", 2'b10, rd_status);
      end
      if (wr_status !== 2'b00) begin
         value_mismatch("wr_status", 2'b00, wr_status);
      end
      if (r_valid !== 1'b0) begin
         value_mismatch("r_valid", 1'b0, r_valid);
      end
      close_test();

      cur_test = "fill";
      drive_cycle(1'b1, $urandom, 1'b0);
      if (rd_status.stop !== 1'b0) begin
         value_mismatch("empty after first write", 1'b0, rd_status.stop);
      end
      fill_up(n);
      if (n + 1 != depth / w_unit) begin
         value_mismatch("writes until full", depth / w_unit, n + 1);
      end
      close_test();

      cur_test = "read back";
      empty_out(n);
      wait_drain();
      if (n != depth) begin
         value_mismatch("reads until empty", depth, n);
      end
      close_test();

      cur_test = "overflow and underflow";
      fill_up(n);
      if (wr_status.err !== 1'b0) begin
         value_mismatch("overflow before", 1'b0, wr_status.err);
      end
      // rejected word must not show up in the read data
      drive_cycle(1'b1, 32'hdead_beef, 1'b0);
      if (wr_status.err !== 1'b1) begin
         value_mismatch("overflow", 1'b1, wr_status.err);
      end
      empty_out(n);
      wait_drain();
      if (rd_status.err !== 1'b0) begin
         value_mismatch("underflow before", 1'b0, rd_status.err);
      end
      drive_cycle(1'b0, '0, 1'b1);
      drive_cycle(1'b0, '0, 1'b0);
      drive_cycle(1'b0, '0, 1'b0);
      if (rd_status.err !== 1'b1) begin
         value_mismatch("underflow", 1'b1, rd_status.err);
      end
      if (wr_status.err !== 1'b1) begin
         value_mismatch("overflow held", 1'b1, wr_status.err);
      end
      close_test();

      cur_test = "random traffic";
      // about four reads per write keeps the level wandering end to end
      for (int i = 0; i < 2000; i++) begin
         drive_cycle($urandom_range(0, 99) < 20, $urandom, $urandom_range(0, 99) < 80);
      end
      empty_out(n);
      wait_drain();
      close_test();

      $display("%0d tests, %0d failed, %0d errors, %0d checks",
               n_tests, n_failed, total_errs, n_checks);
      if (total_errs == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: verilog/asym_fifo.sv
`timescale 1ns/1ns

module asym_fifo import fifo_cfg_pkg::*, fifo_types_pkg::*; #(
   parameter int w_data_w = def_w_data_w,
   parameter int r_data_w = def_r_data_w,
   parameter int addr_w   = def_addr_w
) (
   input  logic                clk,
   input  logic                rst_n,
   // producer
   input  logic                w_en,
   input  logic [w_data_w-1:0] w_data,
   // consumer
   input  logic                r_en,
   output logic [r_data_w-1:0] r_data,
   output logic                r_valid,
   // status
   output fifo_side_t          wr_status,
   output fifo_side_t          rd_status
);

   localparam int w_addr_w = port_addr_w(w_data_w, r_data_w, addr_w);
   localparam int r_addr_w = port_addr_w(r_data_w, w_data_w, addr_w);

   // pointers carry a wrap bit above the RAM address
   logic [w_addr_w:0]   wr_ptr;
   logic [r_addr_w:0]   rd_ptr;
   logic                ram_w_en;
   logic [w_addr_w-1:0] ram_w_addr;
   logic                ram_r_en;
   logic [r_addr_w-1:0] ram_r_addr;
   logic [r_data_w-1:0] ram_r_data;

   fifo_wr_ctrl #(
      .w_data_w (w_data_w),
      .r_data_w (r_data_w),
      .addr_w   (addr_w)
   ) i_wr_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .w_en       (w_en),
      .rd_ptr     (rd_ptr),
      .wr_ptr     (wr_ptr),
      .ram_w_en   (ram_w_en),
      .ram_w_addr (ram_w_addr),
      .wr_status  (wr_status)
   );

   ram_2p_asym #(
      .w_data_w (w_data_w),
      .r_data_w (r_data_w),
      .addr_w   (addr_w)
   ) i_ram (
      .clk    (clk),
      .w_en   (ram_w_en),
      .w_data (w_data),
      .w_addr (ram_w_addr),
      .r_en   (ram_r_en),
      .r_addr (ram_r_addr),
      .r_data (ram_r_data)
   );

   fifo_rd_ctrl #(
      .w_data_w (w_data_w),
      .r_data_w (r_data_w),
      .addr_w   (addr_w)
   ) i_rd_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .r_en       (r_en),
      .wr_ptr     (wr_ptr),
      .rd_ptr     (rd_ptr),
      .ram_r_en   (ram_r_en),
      .ram_r_addr (ram_r_addr),
      .ram_r_data (ram_r_data),
      .r_data     (r_data),
      .r_valid    (r_valid),
      .rd_status  (rd_status)
   );

endmodule

// File: verilog/fifo_cfg_pkg.sv
package fifo_cfg_pkg;

   // configuration the testbench builds
   localparam int def_w_data_w = 32;
   localparam int def_r_data_w = 8;
   // depth as log2 of the narrow entry count
   localparam int def_addr_w = 6;

   function automatic int max_w(input int a, input int b);
      return (a > b) ? a : b;
   endfunction

   function automatic int min_w(input int a, input int b);
      return (a < b) ? a : b;
   endfunction

   // narrow slices per wide word
   function automatic int ratio_of(input int a, input int b);
      return max_w(a, b) / min_w(a, b);
   endfunction

   // address width of a port that is this_w wide, facing a port other_w wide
   function automatic int port_addr_w(input int this_w, input int other_w, input int addr_w);
      if (this_w == max_w(this_w, other_w)) begin
         return addr_w - $clog2(ratio_of(this_w, other_w));
      end
      return addr_w;
   endfunction

endpackage

// File: verilog/fifo_rd_ctrl.sv
`timescale 1ns/1ns

module fifo_rd_ctrl import fifo_cfg_pkg::*, fifo_types_pkg::*; #(
   parameter  int w_data_w = def_w_data_w,
   parameter  int r_data_w = def_r_data_w,
   parameter  int addr_w   = def_addr_w,
   localparam int w_addr_w = port_addr_w(w_data_w, r_data_w, addr_w),
   localparam int r_addr_w = port_addr_w(r_data_w, w_data_w, addr_w)
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                r_en,
   input  logic [w_addr_w:0]   wr_ptr,
   output logic [r_addr_w:0]   rd_ptr,
   output logic                ram_r_en,
   output logic [r_addr_w-1:0] ram_r_addr,
   input  logic [r_data_w-1:0] ram_r_data,
   output logic [r_data_w-1:0] r_data,
   output logic                r_valid,
   output fifo_side_t          rd_status
);

   localparam int w_shift = addr_w - w_addr_w;
   localparam int r_shift = addr_w - r_addr_w;

   typedef logic [addr_w:0] level_t;

   // narrow entries consumed by one read
   localparam level_t r_unit = level_t'(2**r_shift);

   level_t wr_pos;
   level_t rd_pos;
   level_t fill;
   logic   empty;
   logic   underflow;

   assign wr_pos = level_t'(wr_ptr) << w_shift;
   assign rd_pos = level_t'(rd_ptr) << r_shift;
   assign fill   = wr_pos - rd_pos;

   // less than one whole read word stored
   assign empty = fill < r_unit;

   assign ram_r_en   = r_en && !empty;
   assign ram_r_addr = rd_ptr[r_addr_w-1:0];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_ptr    <= '0;
         r_valid   <= 1'b0;
         underflow <= 1'b0;
      end else begin
         if (ram_r_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // marks the cycle the RAM output carries the word
         r_valid <= ram_r_en;
         if (r_en && empty) begin
            underflow <= 1'b1;
         end
      end
   end

   // RAM read port is already registered
   assign r_data = ram_r_data;

   assign rd_status = '{stop: empty, err: underflow};

   // reads only reach entries that were written
   a_data_known : assert property (@(posedge clk) disable iff (!rst_n)
      r_valid |-> !$isunknown(r_data))
      else $error("fifo_rd_ctrl: read data unknown on r_valid");

endmodule

// File: verilog/fifo_types_pkg.sv
package fifo_types_pkg;

   // status of one FIFO side
   // stop is full on the write side and empty on the read side,
   // err is the sticky overflow or underflow of that side
   typedef struct packed {
      logic stop;
      logic err;
   } fifo_side_t;

endpackage

// File: verilog/fifo_wr_ctrl.sv
`timescale 1ns/1ns

module fifo_wr_ctrl import fifo_cfg_pkg::*, fifo_types_pkg::*; #(
   parameter  int w_data_w = def_w_data_w,
   parameter  int r_data_w = def_r_data_w,
   parameter  int addr_w   = def_addr_w,
   localparam int w_addr_w = port_addr_w(w_data_w, r_data_w, addr_w),
   localparam int r_addr_w = port_addr_w(r_data_w, w_data_w, addr_w)
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                w_en,
   input  logic [r_addr_w:0]   rd_ptr,
   output logic [w_addr_w:0]   wr_ptr,
   output logic                ram_w_en,
   output logic [w_addr_w-1:0] ram_w_addr,
   output fifo_side_t          wr_status
);

   // pointers scaled to narrow entries with the wrap bit kept on top
   localparam int w_shift = addr_w - w_addr_w;
   localparam int r_shift = addr_w - r_addr_w;

   typedef logic [addr_w:0] level_t;

   localparam level_t depth  = level_t'(2**addr_w);
   // narrow entries taken by one write
   localparam level_t w_unit = level_t'(2**w_shift);

   level_t wr_pos;
   level_t rd_pos;
   level_t fill;
   logic   full;
   logic   overflow;

   assign wr_pos = level_t'(wr_ptr) << w_shift;
   assign rd_pos = level_t'(rd_ptr) << r_shift;
   assign fill   = wr_pos - rd_pos;

   // not enough room left for a whole write word
   assign full = (depth - fill) < w_unit;

   assign ram_w_en   = w_en && !full;
   assign ram_w_addr = wr_ptr[w_addr_w-1:0];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr   <= '0;
         overflow <= 1'b0;
      end else begin
         if (ram_w_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         // overflow on a dropped write holds until reset
         if (w_en && full) begin
            overflow <= 1'b1;
         end
      end
   end

   assign wr_status = '{stop: full, err: overflow};

   // read pointer never passes the write pointer
   a_fill_range : assert property (@(posedge clk) disable iff (!rst_n) fill <= depth)
      else $error("fifo_wr_ctrl: fill level out of range");

endmodule

// File: verilog/ram_2p.sv
`timescale 1ns/1ns

module ram_2p #(
   parameter int data_w = 8,
   parameter int addr_w = 6
) (
   input  logic              clk,
   input  logic              w_en,
   input  logic [addr_w-1:0] w_addr,
   input  logic [data_w-1:0] w_data,
   input  logic              r_en,
   input  logic [addr_w-1:0] r_addr,
   output logic [data_w-1:0] r_data
);

   logic [data_w-1:0] mem [2**addr_w];

   always_ff @(posedge clk) begin
      if (w_en) begin
         mem[w_addr] <= w_data;
      end
   end

   // output holds its last word while r_en is low
   always_ff @(posedge clk) begin
      if (r_en) begin
         r_data <= mem[r_addr];
      end
   end

endmodule

// File: verilog/ram_2p_asym.sv
`timescale 1ns/1ns

module ram_2p_asym import fifo_cfg_pkg::*; #(
   parameter  int w_data_w = def_w_data_w,
   parameter  int r_data_w = def_r_data_w,
   parameter  int addr_w   = def_addr_w,
   localparam int w_addr_w = port_addr_w(w_data_w, r_data_w, addr_w),
   localparam int r_addr_w = port_addr_w(r_data_w, w_data_w, addr_w)
) (
   input  logic                clk,
   // write port
   input  logic                w_en,
   input  logic [w_data_w-1:0] w_data,
   input  logic [w_addr_w-1:0] w_addr,
   // read port
   input  logic                r_en,
   input  logic [r_addr_w-1:0] r_addr,
   output logic [r_data_w-1:0] r_data
);

   localparam int n          = ratio_of(w_data_w, r_data_w);
   localparam int blk_w      = min_w(w_data_w, r_data_w);
   // low address bits that pick a block
   localparam int sel_w      = $clog2(n);
   localparam int blk_addr_w = addr_w - sel_w;

   logic [n-1:0]            blk_w_en;
   logic [blk_w-1:0]        blk_w_data [n];
   logic [blk_addr_w-1:0]   blk_w_addr;
   logic [blk_addr_w-1:0]   blk_r_addr;
   logic [blk_w-1:0]        blk_r_data [n];

   // block i holds slice i of every wide word
   for (genvar i = 0; i < n; i++) begin : g_blk
      ram_2p #(
         .data_w (blk_w),
         .addr_w (blk_addr_w)
      ) i_ram (
         .clk    (clk),
         .w_en   (blk_w_en[i]),
         .w_addr (blk_w_addr),
         .w_data (blk_w_data[i]),
         .r_en   (r_en),
         .r_addr (blk_r_addr),
         .r_data (blk_r_data[i])
      );
   end

   if (w_data_w > r_data_w) begin : g_wide_wr
      logic [sel_w-1:0] r_sel_q;

      // all slices of a wide word land at once
      for (genvar i = 0; i < n; i++) begin : g_slice
         assign blk_w_en[i]   = w_en;
         assign blk_w_data[i] = w_data[i*blk_w +: blk_w];
      end
      assign blk_w_addr = w_addr;
      assign blk_r_addr = r_addr[r_addr_w-1 -: blk_addr_w];

      // block select follows the registered read data
      always_ff @(posedge clk) begin
         if (r_en) begin
            r_sel_q <= r_addr[sel_w-1:0];
         end
      end
      assign r_data = blk_r_data[r_sel_q];

   end else if (w_data_w < r_data_w) begin : g_wide_rd
      // narrow writes rotate through the blocks, lowest slice first
      for (genvar i = 0; i < n; i++) begin : g_slice
         assign blk_w_en[i]   = w_en && (w_addr[sel_w-1:0] == sel_w'(i));
         assign blk_w_data[i] = w_data;
         assign r_data[i*blk_w +: blk_w] = blk_r_data[i];
      end
      assign blk_w_addr = w_addr[w_addr_w-1 -: blk_addr_w];
      assign blk_r_addr = r_addr;

   end else begin : g_equal
      assign blk_w_en[0]   = w_en;
      assign blk_w_data[0] = w_data;
      assign blk_w_addr    = w_addr;
      assign blk_r_addr    = r_addr;
      assign r_data        = blk_r_data[0];
   end

   // addresses come from the controllers and must be known when used
   a_w_addr_known : assert property (@(posedge clk) w_en |-> !$isunknown(w_addr))
      else $error("ram_2p_asym: write with unknown address");

   a_r_addr_known : assert property (@(posedge clk) r_en |-> !$isunknown(r_addr))
      else $error("ram_2p_asym: read with unknown address");

endmodule
